//--- hw/hr_16t4_mux.sv
`timescale 1ns/1ps
`include "tx_settings.svh"

module hr_16t4_mux (
    input  logic                  tx_clk,
    input  logic                  arst_n,
    input  tx_pkg::tx_cfg_t       cfg,
    input  logic [`TX_WORD_W-1:0] din,        // External word
    input  logic [`TX_WORD_W-1:0] prbs_word,  // Generator word
    input  logic                  word_take,
    input  logic                  nib_en,
    output logic [`TX_LANES-1:0]  nib         // To quarter-rate mux
);

    import tx_pkg::*;

    localparam int NIB_N = `TX_WORD_W / `TX_LANES;  // Nibbles per word
    localparam int IDX_W = $clog2(NIB_N);

    logic [`TX_WORD_W-1:0] word_q;   // Held word
    logic [IDX_W-1:0]      idx_q;    // Nibble being offered

    //////////////////////////////////////////////////////////////
    // Word capture
    //////////////////////////////////////////////////////////////

    always_ff @(posedge tx_clk) begin
        if (word_take) begin
            word_q <= (cfg.src == SRC_PRBS) ? prbs_word : din;
        end
    end

    //////////////////////////////////////////////////////////////
    // Nibble sequencing
    //////////////////////////////////////////////////////////////

    // Restart at the lowest nibble on every new word
    always_ff @(posedge tx_clk or negedge arst_n) begin
        if (!arst_n) begin
            idx_q <= '0;
        end else if (!cfg.enable || word_take) begin
            idx_q <= '0;
        end else if (nib_en) begin
            idx_q <= idx_q + 1'b1;  // Next nibble after each load
        end
    end

    // Lowest nibble first
    assign nib = word_q[idx_q*`TX_LANES +: `TX_LANES];

endmodule

//--- hw/prbs_gen.sv
`timescale 1ns/1ps
`include "tx_settings.svh"

module prbs_gen (
    input  logic                  tx_clk,
    input  logic                  arst_n,
    input  tx_pkg::tx_cfg_t       cfg,
    input  logic                  word_take,  // Advance one word
    output logic [`TX_WORD_W-1:0] prbs_word   // Next word, bit 0 first out
);

    logic [6:0]            lfsr_q;     // PRBS7 state
    logic [6:0]            lfsr_nxt;   // State after one word
    logic [`TX_WORD_W-1:0] word_nxt;

    //////////////////////////////////////////////////////////////
    // Unrolled x^7+x^6+1 stepping
    //////////////////////////////////////////////////////////////

    always_comb begin : step_word
        logic [6:0] s;
        logic       fb;
        s  = lfsr_q;
        fb = 1'b0;
        for (int i = 0; i < `TX_WORD_W; i++) begin
            fb          = s[6] ^ s[5];   // Taps 7 and 6
            word_nxt[i] = fb;            // First bit to bit 0
            s           = {s[5:0], fb};
        end
        lfsr_nxt = s;
    end

    // Seed all ones while disabled so each enable restarts the sequence
    always_ff @(posedge tx_clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr_q <= '1;
        end else if (!cfg.enable) begin
            lfsr_q <= '1;
        end else if (word_take) begin
            lfsr_q <= lfsr_nxt;     // 16 steps per word
        end
    end

    // Word is ready before word_take samples it
    assign prbs_word = word_nxt;

endmodule

//--- hw/qr_4t1_mux.sv
`timescale 1ns/1ps
`include "tx_settings.svh"

module qr_4t1_mux (
    input  logic                 tx_clk,
    input  logic                 arst_n,
    input  tx_pkg::tx_cfg_t      cfg,
    input  logic                 nib_en,   // Load strobe
    input  logic [`TX_LANES-1:0] nib,
    output logic                 dout_p,   // Serial pair
    output logic                 dout_n
);

    localparam int DLY_N = 1 << `TX_PI_W;  // Delay line taps

    logic [`TX_LANES-1:0] shift_q;  // Nibble shifter
    logic [DLY_N-1:0]     dly_q;    // Whole-bit delay line
    logic                 tap;
    logic                 bit_pol;

    //////////////////////////////////////////////////////////////
    // Nibble to serial and phase delay
    //////////////////////////////////////////////////////////////

    always_ff @(posedge tx_clk) begin
        if (!cfg.enable) begin
            shift_q <= '0;
            dly_q   <= '0;
        end else begin
            if (nib_en) begin
                shift_q <= nib;              // LSB leaves first
            end else begin
                shift_q <= shift_q >> 1;
            end
            dly_q <= {dly_q[DLY_N-2:0], shift_q[0]};
        end
    end

    assign tap     = dly_q[cfg.pi_code];    // Stands in for the interpolator
    assign bit_pol = tap ^ cfg.invert;      // Polarity swap

    // Output register with electrical idle
    always_ff @(posedge tx_clk or negedge arst_n) begin
        if (!arst_n) begin
            dout_p <= 1'b0;
            dout_n <= 1'b0;
        end else if (!cfg.enable) begin
            dout_p <= 1'b0;                 // Both legs low when idle
            dout_n <= 1'b0;
        end else begin
            dout_p <= bit_pol;
            dout_n <= ~bit_pol;
        end
    end

    // Pair stays complementary once the output register saw enable
    a_diff_pair: assert property (
        @(posedge tx_clk) disable iff (!arst_n)
        (cfg.enable && $past(cfg.enable)) |-> (dout_n == ~dout_p)
    ) else $error("dout_n not the inverse of dout_p while enabled");

endmodule

//--- hw/tx_cfg_port.sv
`timescale 1ns/1ps

module tx_cfg_port (
    input  logic            tx_clk,
    input  logic            arst_n,
    input  logic            cfg_req,   // Four-phase request
    input  tx_pkg::tx_cfg_t cfg_data,  // Stable while cfg_req high
    output logic            cfg_ack,
    output tx_pkg::tx_cfg_t cfg        // Active configuration
);

    import tx_pkg::*;

    cfg_state_e state_q;
    cfg_state_e state_nxt;

    // Handshake sequencing
    always_comb begin
        state_nxt = state_q;
        unique case (state_q)
            CFG_IDLE: begin
                if (cfg_req) begin
                    state_nxt = CFG_ACK;      // Latch and ack together
                end
            end
            CFG_ACK: begin
                if (!cfg_req) begin
                    state_nxt = CFG_WAIT_LOW; // Ack falls one cycle after req
                end
            end
            CFG_WAIT_LOW: state_nxt = CFG_IDLE;
            default:      state_nxt = CFG_IDLE;
        endcase
    end

    // State and active config registers
    always_ff @(posedge tx_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= CFG_IDLE;
            cfg     <= '0;          // Disabled after reset
        end else begin
            state_q <= state_nxt;
            // Copy on entry to CFG_ACK
            if (state_q == CFG_IDLE && cfg_req) begin
                cfg <= cfg_data;
            end
        end
    end

    assign cfg_ack = (state_q == CFG_ACK);

    //////////////////////////////////////////////////////////////
    // Handshake checks
    //////////////////////////////////////////////////////////////

    // Ack only answers a pending request
    a_ack_after_req: assert property (
        @(posedge tx_clk) disable iff (!arst_n)
        $rose(cfg_ack) |-> $past(cfg_req)
    ) else $error("cfg_ack rose without cfg_req");

    // Config is frozen for the whole ack phase
    a_cfg_stable: assert property (
        @(posedge tx_clk) disable iff (!arst_n)
        (cfg_ack && $past(cfg_ack)) |-> $stable(cfg)
    ) else $error("cfg changed while cfg_ack held");

endmodule

//--- hw/tx_clk_div.sv
`timescale 1ns/1ps
`include "tx_settings.svh"

module tx_clk_div (
    input  logic            tx_clk,
    input  logic            arst_n,
    input  tx_pkg::tx_cfg_t cfg,
    output logic            word_take,  // One cycle per word
    output logic            nib_en      // One cycle per nibble
);

    localparam int CNT_W  = $clog2(`TX_WORD_W);  // Bit phase within the word
    localparam int LANE_W = $clog2(`TX_LANES);   // Bit phase within the nibble

    logic [CNT_W-1:0] phase_q;

    //////////////////////////////////////////////////////////////
    // Bit-phase counter
    //////////////////////////////////////////////////////////////

    // Cleared while disabled so the first word_take
    // lands on the first edge with enable high
    always_ff @(posedge tx_clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_q <= '0;
        end else if (!cfg.enable) begin
            phase_q <= '0;                // Hold at phase 0
        end else begin
            phase_q <= phase_q + 1'b1;    // Wraps every word
        end
    end

    // Word rate strobe at phase 0
    assign word_take = cfg.enable && (phase_q == '0);

    // Quarter-rate strobe one cycle after each multiple of four
    // Enable gate covers the cycle right after a disable
    assign nib_en = cfg.enable && (phase_q[LANE_W-1:0] == LANE_W'(1));

    //////////////////////////////////////////////////////////////
    // Idle check
    //////////////////////////////////////////////////////////////

    // No strobes escape while the link is idle
    a_idle_no_strobe: assert property (
        @(posedge tx_clk) disable iff (!arst_n)
        !cfg.enable |-> (!word_take && !nib_en)
    ) else $error("word_take or nib_en high while disabled");

endmodule

//--- hw/tx_pkg.sv
`include "tx_settings.svh"

package tx_pkg;

    //////////////////////////////////////////////////////////////
    // Configuration types
    //////////////////////////////////////////////////////////////

    // Word source for the serializer
    typedef enum logic {
        SRC_EXT  = 1'b0,  // External din bus
        SRC_PRBS = 1'b1   // Internal PRBS7 generator
    } tx_src_e;

    // Active configuration, five bits in total
    typedef struct packed {
        logic                enable;   // Transmitter on
        tx_src_e             src;      // Word source
        logic [`TX_PI_W-1:0] pi_code;  // Whole-bit output delay
        logic                invert;   // Swap dout_p and dout_n
    } tx_cfg_t;

    //////////////////////////////////////////////////////////////
    // Config port FSM
    //////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        CFG_IDLE     = 2'd0,  // Waiting for cfg_req
        CFG_ACK      = 2'd1,  // cfg_ack high until cfg_req drops
        CFG_WAIT_LOW = 2'd2   // One guard cycle with ack low
    } cfg_state_e;

endpackage

//--- hw/tx_settings.svh
`ifndef TX_SETTINGS_SVH
`define TX_SETTINGS_SVH

//////////////////////////////////////////////////////////////
// Serializer dimensions
//////////////////////////////////////////////////////////////

// Parallel word width, one word per word_take
`define TX_WORD_W 16

// Quarter-rate lanes, equal to the nibble width
`define TX_LANES  4

// Phase code width, whole-bit output delay of 0 to 3 bits
`define TX_PI_W   2

`endif

//--- hw/tx_top.sv
`timescale 1ns/1ps
`include "tx_settings.svh"

module tx_top (
    input  logic                  tx_clk,     // Serial bit rate clock
    input  logic                  arst_n,
    input  logic                  cfg_req,
    input  tx_pkg::tx_cfg_t       cfg_data,
    output logic                  cfg_ack,
    input  logic [`TX_WORD_W-1:0] din,
    output logic                  word_take,  // din consumed this edge
    output logic                  dout_p,
    output logic                  dout_n
);

    import tx_pkg::*;

    tx_cfg_t               cfg;        // Active configuration
    logic                  nib_en;     // Quarter-rate enable
    logic [`TX_WORD_W-1:0] prbs_word;
    logic [`TX_LANES-1:0]  nib;        // Half-rate to quarter-rate lanes

    //////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////

    tx_cfg_port i_cfg_port (
        .tx_clk   (tx_clk),
        .arst_n   (arst_n),
        .cfg_req  (cfg_req),
        .cfg_data (cfg_data),
        .cfg_ack  (cfg_ack),
        .cfg      (cfg)
    );

    tx_clk_div i_clk_div (
        .tx_clk    (tx_clk),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .word_take (word_take),
        .nib_en    (nib_en)
    );

    //////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////

    prbs_gen i_prbs_gen (
        .tx_clk    (tx_clk),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .word_take (word_take),
        .prbs_word (prbs_word)
    );

    // 16 to 4 stage
    hr_16t4_mux i_hr_mux (
        .tx_clk    (tx_clk),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .din       (din),
        .prbs_word (prbs_word),
        .word_take (word_take),
        .nib_en    (nib_en),
        .nib       (nib)
    );

    // 4 to 1 stage and output driver
    qr_4t1_mux i_qr_mux (
        .tx_clk (tx_clk),
        .arst_n (arst_n),
        .cfg    (cfg),
        .nib_en (nib_en),
        .nib    (nib),
        .dout_p (dout_p),
        .dout_n (dout_n)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the serializer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tx_top -f tb.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_tx_top)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only when the testbench reported it
if printf '%s\n' "$out" | grep -qx "All checks passed"; then
    exit 0
fi
echo "Simulation reported failure"
exit 1

//--- tb.f
+incdir+hw
hw/tx_pkg.sv
hw/tx_cfg_port.sv
hw/tx_clk_div.sv
hw/prbs_gen.sv
hw/hr_16t4_mux.sv
hw/qr_4t1_mux.sv
hw/tx_top.sv
tb/tb_tx_top.sv

//--- tb/tb_tx_top.sv
`timescale 1ns/1ps
`include "tx_settings.svh"

module tb_tx_top;

    import tx_pkg::*;

    localparam int N_SEG     = 8;    // Phase code and source sweep
    localparam int N_WORDS   = 40;   // Words per segment
    localparam int WD_CYCLES = N_SEG * (N_WORDS * `TX_WORD_W + 50);
    localparam int HS_LIMIT  = 16;   // Cycles allowed per handshake phase

    logic                  tx_clk;
    logic                  arst_n;
    logic                  cfg_req;
    tx_cfg_t               cfg_data;
    logic                  cfg_ack;
    logic [`TX_WORD_W-1:0] din;
    logic                  word_take;
    logic                  dout_p;
    logic                  dout_n;

    integer  seed;
    int      err_cnt    = 0;
    int      edge_cnt   = 0;   // Rising edges so far
    tx_cfg_t cur_cfg;          // Last config written
    logic    prbs_hist[$];     // Last seven PRBS bits with the oldest first
    int      due_q[$];         // Edge at which each bit is on dout_p
    logic    bit_q[$];
    int      words_left;       // Words still to be modeled
    int      last_take;        // Edge of previous word_take
    int      first_take;       // Edge of first word_take after enable
    logic    idle_chk;
    logic    diff_chk;
    logic    take_seen;

    tx_top i_dut (
        .tx_clk    (tx_clk),
        .arst_n    (arst_n),
        .cfg_req   (cfg_req),
        .cfg_data  (cfg_data),
        .cfg_ack   (cfg_ack),
        .din       (din),
        .word_take (word_take),
        .dout_p    (dout_p),
        .dout_n    (dout_n)
    );

    // 100 ns bit clock with the edge count bumped just before the rise
    initial begin
        tx_clk = 1'b0;
        forever begin
            #50;
            edge_cnt = edge_cnt + 1;
            tx_clk   = 1'b1;
            #50;
            tx_clk   = 1'b0;
        end
    end

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Next PRBS7 bit from b[n] = b[n-7] ^ b[n-6]
    function automatic logic prbs7_bit();
        logic b;
        b = prbs_hist[0] ^ prbs_hist[1];
        prbs_hist.push_back(b);
        void'(prbs_hist.pop_front());
        return b;
    endfunction

    //////////////////////////////////////////////////////////////
    // Four-phase config write
    //////////////////////////////////////////////////////////////

    task automatic write_cfg(input tx_cfg_t data);
        int waited;
        @(posedge tx_clk);
        cfg_req  <= 1'b1;
        cfg_data <= data;
        cur_cfg   = data;
        if (data.enable) begin
            first_take = edge_cnt + 2;   // Latch on the next edge and take on the one after
            last_take  = -1;
        end
        @(negedge tx_clk);
        compare("cfg_ack", cfg_ack, 1'b0);  // Req not sampled yet
        waited = 0;
        while (!cfg_ack && waited < HS_LIMIT) begin
            @(negedge tx_clk);
            waited++;
        end
        if (!cfg_ack) begin
            err_cnt++;
            $display("cfg_ack never rose after cfg_req at t=%0t", $time);
        end
        @(posedge tx_clk);
        cfg_req <= 1'b0;
        @(negedge tx_clk);
        compare("cfg_ack", cfg_ack, 1'b1);  // Held until req seen low
        waited = 0;
        while (cfg_ack && waited < HS_LIMIT) begin
            @(negedge tx_clk);
            waited++;
        end
        if (cfg_ack) begin
            err_cnt++;
            $display("cfg_ack stayed high after cfg_req fell at t=%0t", $time);
        end
    endtask

    //////////////////////////////////////////////////////////////
    // One test segment
    //////////////////////////////////////////////////////////////

    task automatic run_segment(input int seg);
        tx_cfg_t c;
        int      waited;
        diff_chk = 1'b0;
        c = '0;
        write_cfg(c);                        // Link idle
        due_q.delete();
        bit_q.delete();
        idle_chk  = 1'b1;
        c.src     = tx_src_e'(seg[2]);       // Sweep source and phase
        c.pi_code = seg[1:0];
        c.invert  = 1'($random(seed));       // Random polarity
        write_cfg(c);
        prbs_hist.delete();
        repeat (7) prbs_hist.push_back(1'b1); // All-ones seed
        words_left = N_WORDS;
        idle_chk   = 1'b0;
        c.enable   = 1'b1;
        write_cfg(c);
        diff_chk = 1'b1;
        waited   = 0;
        while ((words_left > 0 || due_q.size() > 0) && waited < N_WORDS * 16 + 64) begin
            @(negedge tx_clk);
            waited++;
        end
        if (words_left > 0 || due_q.size() > 0) begin
            err_cnt++;
            $display("Segment %0d: bit stream did not complete", seg);
        end
    endtask

    // New din right after each capture edge
    always @(posedge tx_clk) begin
        if (take_seen) begin
            din      <= `TX_WORD_W'($random(seed));
            take_seen = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////
    // Monitor samples all outputs at the falling edge
    //////////////////////////////////////////////////////////////

    always @(negedge tx_clk) begin : monitor
        logic [`TX_WORD_W-1:0] w;
        int                    t;
        logic                  exp_bit;
        if (idle_chk) begin
            compare("word_take", word_take, 1'b0);
            compare("dout_p", dout_p, 1'b0);
            compare("dout_n", dout_n, 1'b0);
        end
        if (diff_chk) begin
            compare("dout_p^dout_n", dout_p ^ dout_n, 1'b1);  // Legs always opposite
        end
        while (due_q.size() > 0 && due_q[0] < edge_cnt) begin
            err_cnt++;
            $display("Expected bit due at edge %0d was never checked", due_q[0]);
            void'(due_q.pop_front());
            void'(bit_q.pop_front());
        end
        if (due_q.size() > 0 && due_q[0] == edge_cnt) begin
            exp_bit = bit_q[0] ^ cur_cfg.invert;  // Invert swaps the pair
            compare("dout_p", dout_p, exp_bit);
            compare("dout_n", dout_n, !exp_bit);
            void'(due_q.pop_front());
            void'(bit_q.pop_front());
        end
        // word_take high now means capture on the coming edge
        if (word_take) begin
            t = edge_cnt + 1;
            if (last_take < 0) begin
                compare("word_take edge", t, first_take);
            end else begin
                compare("word_take period", t - last_take, `TX_WORD_W);
            end
            last_take = t;
            if (words_left > 0) begin
                for (int k = 0; k < `TX_WORD_W; k++) begin
                    w[k] = (cur_cfg.src == SRC_PRBS) ? prbs7_bit() : din[k];
                end
                for (int k = 0; k < `TX_WORD_W; k++) begin
                    due_q.push_back(t + 3 + int'(cur_cfg.pi_code) + k);
                    bit_q.push_back(w[k]);      // LSB first
                end
                words_left--;
            end
            take_seen = 1'b1;
        end
    end

    initial begin : watchdog
        repeat (WD_CYCLES) @(posedge tx_clk);
        $display("Timeout: run did not finish within %0d cycles", WD_CYCLES);
        $display("Errors: %0d", err_cnt);
        $display("Checks failed");
        $finish;
    end

    initial begin : main
        seed       = 32'h5f9fe3a4;
        arst_n     = 1'b0;
        cfg_req    = 1'b0;
        cfg_data   = '0;
        din        = `TX_WORD_W'($random(seed));
        cur_cfg    = '0;
        words_left = 0;
        last_take  = -1;
        first_take = 0;
        idle_chk   = 1'b1;   // Idle from reset on
        diff_chk   = 1'b0;
        take_seen  = 1'b0;
        repeat (3) @(posedge tx_clk);
        arst_n <= 1'b1;
        for (int s = 0; s < N_SEG; s++) begin
            run_segment(s);
        end
        diff_chk = 1'b0;
        write_cfg('0);
        idle_chk = 1'b1;
        repeat (4) @(negedge tx_clk);
        $display("Errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
